// File: sim.f
+incdir+.
defines.sv
decode.sv
regfile.sv
alu.sv
dmem.sv
wb.sv
core_top.sv
core_sva.sv
tb_core.sv

// File: Makefile
# Verilator build and run of the core testbench.

all: run

obj_dir/Vtb_core: sim.f $(wildcard *.sv *.svh)
	verilator --binary --assert -Wno-fatal --top-module tb_core -f sim.f -Mdir obj_dir

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: tb_core.sv
`timescale 1ns/1ps
`include "core_params.svh"

module tb_core;

	logic clk;
	logic rst;
	defines::in_t core_in;
	defines::retire_t retire;

	integer seed;
	int cyc = 0;
	int n_checked = 0;
	int n_mismatch = 0;
	int n_other = 0;

	// Architectural state of the model, kept in program order.
	// Only x0 to x7 are ever named by the stream.
	defines::data_t pc;
	defines::data_t regs [8];
	defines::data_t mem [`DMEM_WORDS];

	// Expected retire reports and the rising-edge count at which each was sent.
	defines::retire_t exp_q [$];
	int stamp_q [$];

	core_top u_core_top (
		.clk    (clk),
		.rst    (rst),
		.in     (core_in),
		.retire (retire)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic defines::data_t sext(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// Word index is the byte address above bit 1, wrapped to the memory depth.
	function automatic int word_index(input defines::data_t addr);
		return int'((addr >> 2) % `DMEM_WORDS);
	endfunction

	// RV32I integer operation selected by funct3, with alt picking SUB and SRA.
	function automatic defines::data_t alu_model(input logic [2:0] f3, input logic alt,
			input defines::data_t a, input defines::data_t b);
		defines::data_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) r = $signed(a) >>> b[4:0];
				else r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic report(input string field, input defines::data_t got,
			input defines::data_t want, input defines::data_t at_pc);
		n_mismatch++;
		$display("MISMATCH t=%0t pc=%h %s: got %h, expected %h", $time, at_pc, field, got, want);
	endtask

	task automatic check_retire(input defines::retire_t got, input defines::retire_t want);
		n_checked++;
		if (got.pc !== want.pc) report("pc", got.pc, want.pc, want.pc);
		if (got.instr !== want.instr) report("instr", got.instr, want.instr, want.pc);
		if (got.we !== want.we) report("we", 32'(got.we), 32'(want.we), want.pc);
		if (got.rd !== want.rd) report("rd", 32'(got.rd), 32'(want.rd), want.pc);
		if (got.data !== want.data) report("data", got.data, want.data, want.pc);
	endtask

	// Draws one instruction, runs it on the model and drives it into the core.
	// Kind 0-4 is R, 5-9 I, 10 LUI, 11 AUIPC, 12 JAL, 13 JALR, 14-15 LW, 16-17 SW,
	// 18 a branch and 19 FENCE or SYSTEM.
	task automatic send_item();
		defines::instr_t ins;
		defines::retire_t want;
		defines::data_t res;
		defines::data_t addr;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		logic alt;
		int kind;
		kind = rnd(20);
		rd = 5'(rnd(8));
		rs1 = 5'(rnd(8));
		rs2 = 5'(rnd(8));
		f3 = 3'(rnd(8));
		imm = 12'($random(seed));
		alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rnd(2)) : 1'b0;
		res = defines::NULL;
		// Fields a format does not name keep their random bits.
		ins = defines::instr_t'($random(seed));
		ins.r.rd = rd;
		ins.r.funct3 = f3;
		ins.r.rs1 = rs1;
		ins.r.rs2 = rs2;
		if (kind < 5) begin
			ins.r.funct7 = {1'b0, alt, 5'd0};
			ins.r.opcode = defines::R;
			res = alu_model(f3, alt, regs[rs1], regs[rs2]);
		end else if (kind < 10) begin
			// ADDI has no subtract; shift immediates carry the SRA bit at imm[10].
			if (f3 != 3'd5) alt = 1'b0;
			if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'd0, imm[4:0]};
			ins.i.imm12 = imm;
			ins.i.opcode = defines::I;
			res = alu_model(f3, alt, regs[rs1], sext(imm));
		end else if (kind < 12) begin
			ins.u.opcode = (kind == 10) ? defines::LUI : defines::AUIPC;
			res = {ins.u.imm20, 12'd0};
			if (kind == 11) res = pc + res;
		end else if (kind < 14) begin
			ins.u.opcode = (kind == 12) ? defines::JAL : defines::JALR;
			if (kind == 13) ins.i.funct3 = 3'd0;
			res = pc + 32'd4;
		end else if (kind < 18) begin
			// Half the accesses hit a few low words off x0, so loads meet earlier stores.
			if (rnd(2) == 0) begin
				rs1 = 5'd0;
				imm = {7'd0, 3'(rnd(8)), 2'd0};
			end
			addr = regs[rs1] + sext(imm);
			ins.r.rs1 = rs1;
			ins.r.funct3 = 3'b010;
			if (kind < 16) begin
				ins.i.imm12 = imm;
				ins.i.opcode = defines::LOAD;
				res = mem[word_index(addr)];
			end else begin
				ins.s.imm_hi = imm[11:5];
				ins.s.imm_lo = imm[4:0];
				ins.s.opcode = defines::STORE;
				mem[word_index(addr)] = regs[rs2];
			end
		end else if (kind == 18) begin
			if (f3 == 3'd2 || f3 == 3'd3) ins.r.funct3 = 3'd0;
			ins.s.opcode = defines::B;
		end else begin
			ins.r.opcode = rnd(2) ? defines::MEM : defines::SYS;
		end
		// Kinds below 16 name a destination register.
		// The rest report rd as zero.
		want.valid = 1'b1;
		want.pc = pc;
		want.instr = ins;
		want.rd = (kind < 16) ? rd : 5'd0;
		want.we = (want.rd != 5'd0);
		want.data = want.we ? res : defines::NULL;
		if (want.we) regs[rd] = res;
		exp_q.push_back(want);
		stamp_q.push_back(cyc);
		core_in.valid = 1'b1;
		core_in.pc = pc;
		core_in.instr = ins;
		pc = pc + 32'd4;
	endtask

	// An item sent after edge n must retire in the cycle after edge n+2.
	always @(negedge clk) begin : monitor
		defines::retire_t want;
		int stamp;
		if (!rst) begin
			if (retire.valid) begin
				if (exp_q.size() == 0) begin
					n_other++;
					$display("ERROR t=%0t: an instruction retired that was never sent", $time);
				end else begin
					want = exp_q.pop_front();
					stamp = stamp_q.pop_front();
					if (stamp + 2 != cyc) begin
						n_other++;
						$display("ERROR t=%0t: pc %h retired at the wrong cycle", $time, want.pc);
					end
					check_retire(retire, want);
				end
			end else if (stamp_q.size() != 0 && stamp_q[0] + 2 <= cyc) begin
				n_other++;
				$display("ERROR t=%0t: pc %h did not retire in time", $time, exp_q[0].pc);
				void'(exp_q.pop_front());
				void'(stamp_q.pop_front());
			end
		end
	end

	initial begin : stimulus
		int waited;
		seed = 32'hdd34_8f08;
		rst = 1'b1;
		core_in = '0;
		pc = 32'h0000_1000;
		for (int n = 0; n < 8; n++) regs[n] = defines::NULL;
		for (int n = 0; n < `DMEM_WORDS; n++) mem[n] = defines::NULL;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// A few quiet cycles; the monitor flags any retire here.
		repeat (4) @(negedge clk);
		for (int n = 0; n < 600; n++) begin
			@(negedge clk);
			if (rnd(5) == 0) begin
				core_in.valid = 1'b0;
				core_in.pc = $random(seed);
				core_in.instr = defines::instr_t'($random(seed));
			end else begin
				send_item();
			end
		end
		@(negedge clk);
		core_in.valid = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			n_other++;
			$display("ERROR: timed out with %0d instructions not retired", exp_q.size());
		end
		$display("Checked %0d retires: %0d mismatches, %0d other errors",
			n_checked, n_mismatch, n_other);
		if (n_mismatch == 0 && n_other == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule : tb_core

// File: core_sva.sv
`timescale 1ns/1ps

module core_sva (
	input logic             clk,
	input logic             rst,
	input defines::in_t     in,
	input defines::retire_t retire
);

	// A reset edge clears both stages, so nothing retires in the next cycle.
	assert property (@(posedge clk) rst |=> !retire.valid)
		else $error("retire.valid high right after a reset edge");

	// Branches, stores, FENCE and SYSTEM write no register, and neither does a write to x0.
	// Such an instruction retires with we low and zero data.
	assert property (@(posedge clk) disable iff (rst)
		retire.valid && ((retire.instr.r.opcode inside {defines::B, defines::STORE,
			defines::MEM, defines::SYS}) || (retire.instr.r.rd == 5'd0))
		|-> (!retire.we && (retire.data == defines::NULL)))
		else $error("a non-writing instruction retired with we high or nonzero data");

	// Each valid input retires exactly two edges later; the pipeline never stalls.
	assert property (@(posedge clk) disable iff (rst)
		retire.valid == $past(in.valid, 2))
		else $error("retire.valid does not follow in.valid by two edges");

endmodule : core_sva

bind core_top core_sva u_core_sva (
	.clk    (clk),
	.rst    (rst),
	.in     (in),
	.retire (retire)
);

// File: core_top.sv
`timescale 1ns/1ps

module core_top (
	input  logic             clk,
	input  logic             rst,
	input  defines::in_t     in,
	output defines::retire_t retire
);

	defines::in_t      ex_s;
	defines::wb_stage_t wb_s;
	defines::ctrl_t    ctrl;
	defines::data_t    rf_rdata1;
	defines::data_t    rf_rdata2;
	defines::data_t    rs1_val;
	defines::data_t    rs2_val;
	defines::data_t    alu_a;
	defines::data_t    alu_b;
	defines::data_t    alu_result;
	defines::data_t    mem_data;
	defines::data_t    wb_data;
	logic              rf_we;
	logic              dmem_we;

	// Execute stage register.
	// Only the valid bit is cleared, the payload simply follows the input.
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_s.valid <= 1'b0;
		end else begin
			ex_s.valid <= in.valid;
		end
		ex_s.pc    <= in.pc;
		ex_s.instr <= in.instr;
	end

	decode u_decode (
		.instr (ex_s.instr),
		.ctrl  (ctrl)
	);

	regfile u_regfile (
		.clk    (clk),
		.rst    (rst),
		.rs1    (ctrl.rs1),
		.rs2    (ctrl.rs2),
		.rd     (wb_s.ctrl.rd),
		.we     (rf_we),
		.wdata  (wb_data),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2)
	);

	// The instruction in writeback has not reached the register file yet.
	// Its result is forwarded to a dependent instruction right behind it.
	always_comb begin
		rs1_val = (rf_we && (wb_s.ctrl.rd == ctrl.rs1)) ? wb_data : rf_rdata1;
		rs2_val = (rf_we && (wb_s.ctrl.rd == ctrl.rs2)) ? wb_data : rf_rdata2;
	end

	// AUIPC adds to the pc, all other formats use rs1.
	assign alu_a = (ctrl.opcode == defines::AUIPC) ? ex_s.pc : rs1_val;
	assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_val;

	alu u_alu (
		.op     (ctrl.alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.pc     (ex_s.pc),
		.result (alu_result)
	);

	// The ALU sum is the load or store address.
	assign dmem_we = ex_s.valid && ctrl.mem_we;

	dmem u_dmem (
		.clk   (clk),
		.we    (dmem_we),
		.addr  (alu_result),
		.wdata (rs2_val),
		.rdata (mem_data)
	);

	// Writeback stage register.
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_s.valid <= 1'b0;
		end else begin
			wb_s.valid <= ex_s.valid;
		end
		wb_s.pc         <= ex_s.pc;
		wb_s.instr      <= ex_s.instr;
		wb_s.ctrl       <= ctrl;
		wb_s.alu_result <= alu_result;
	end

	wb u_wb (
		.instr      (wb_s.instr),
		.alu_result (wb_s.alu_result),
		.mem_data   (mem_data),
		.wb_data    (wb_data)
	);

	// A register write happens at the next edge; x0 never counts as written.
	assign rf_we = wb_s.valid && wb_s.ctrl.reg_we && (wb_s.ctrl.rd != 5'd0);

	// The retire report shows zero data whenever nothing is written.
	always_comb begin
		retire.valid = wb_s.valid;
		retire.pc    = wb_s.pc;
		retire.instr = wb_s.instr;
		retire.we    = rf_we;
		retire.rd    = wb_s.ctrl.rd;
		retire.data  = rf_we ? wb_data : defines::NULL;
	end

endmodule : core_top

// File: wb.sv
`timescale 1ns/1ps

module wb (
	input  defines::instr_t instr,
	input  defines::data_t  alu_result,
	input  defines::data_t  mem_data,
	output defines::data_t  wb_data
);

	defines::opcode_t opcode;

	// Every view keeps the opcode at the same bits.
	always_comb begin
		opcode = instr.r.opcode;
	end

	always_comb begin : wb_sel
		unique case (opcode)
			// Arithmetic, upper-immediate and jump results come from the ALU.
			// For jumps that result is already pc+4.
			defines::R, defines::I, defines::LUI, defines::AUIPC,
			defines::JAL, defines::JALR: begin
				wb_data = alu_result;
			end
			// Loads return the word registered by the data memory.
			defines::LOAD: begin
				wb_data = mem_data;
			end
			// Branches, stores, FENCE and SYSTEM leave the registers alone.
			defines::B, defines::STORE, defines::MEM, defines::SYS: begin
				wb_data = defines::NULL;
			end
			default: begin
				wb_data = defines::NULL;
			end
		endcase
	end

endmodule : wb

// File: dmem.sv
`timescale 1ns/1ps
`include "core_params.svh"

module dmem (
	input  logic           clk,
	input  logic           we,
	input  defines::data_t addr,
	input  defines::data_t wdata,
	output defines::data_t rdata
);

	localparam int IDX_W = $clog2(`DMEM_WORDS);

	defines::data_t mem [`DMEM_WORDS];
	logic [IDX_W-1:0] idx;

	// Word index, with the byte offset dropped and the upper bits wrapping.
	assign idx = addr[IDX_W+1:2];

	// The memory comes up cleared in simulation.
	initial begin
		for (int n = 0; n < `DMEM_WORDS; n++) begin
			mem[n] = defines::NULL;
		end
	end

	// Read and write share the edge.
	// The read returns the old word if both hit the same index.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[idx] <= wdata;
		end
		rdata <= mem[idx];
	end

endmodule : dmem

// File: alu.sv
`timescale 1ns/1ps

module alu (
	input  defines::alu_op_t op,
	input  defines::data_t   a,
	input  defines::data_t   b,
	input  defines::data_t   pc,
	output defines::data_t   result
);

	// Shift amount comes from the low five bits of the second operand.
	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			defines::ADD: begin
				result = a + b;
			end
			defines::SUB: begin
				result = a - b;
			end
			defines::SLL: begin
				result = a << shamt;
			end
			defines::SLT: begin
				result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			end
			defines::SLTU: begin
				result = (a < b) ? 32'd1 : 32'd0;
			end
			defines::XOR: begin
				result = a ^ b;
			end
			defines::SRL: begin
				result = a >> shamt;
			end
			defines::SRA: begin
				// Arithmetic shift keeps the sign bit.
				result = $unsigned($signed(a) >>> shamt);
			end
			defines::OR: begin
				result = a | b;
			end
			defines::AND: begin
				result = a & b;
			end
			defines::PASS_B: begin
				// LUI returns the shifted immediate unchanged.
				result = b;
			end
			defines::PC_PLUS4: begin
				// Link value for JAL and JALR.
				result = pc + 32'd4;
			end
			default: begin
				result = defines::NULL;
			end
		endcase
	end

endmodule : alu

// File: regfile.sv
`timescale 1ns/1ps
`include "core_params.svh"

module regfile (
	input  logic          clk,
	input  logic          rst,
	input  logic [4:0]    rs1,
	input  logic [4:0]    rs2,
	input  logic [4:0]    rd,
	input  logic          we,
	input  defines::data_t wdata,
	output defines::data_t rdata1,
	output defines::data_t rdata2
);

	defines::data_t regs [`NREGS];

	// Writes land on the rising edge.
	// A write to x0 is dropped, so that entry stays zero after reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < `NREGS; n++) begin
				regs[n] <= defines::NULL;
			end
		end else if (we && (rd != 5'd0)) begin
			regs[rd] <= wdata;
		end
	end

	// Reads are combinational.
	// A write on this edge is seen only after the edge, so the core bypasses it.
	always_comb begin
		rdata1 = (rs1 == 5'd0) ? defines::NULL : regs[rs1];
		rdata2 = (rs2 == 5'd0) ? defines::NULL : regs[rs2];
	end

endmodule : regfile

// File: decode.sv
`timescale 1ns/1ps

module decode (
	input  defines::instr_t instr,
	output defines::ctrl_t  ctrl
);

	// Maps funct3 to an ALU operation.
	// The alt bit is instr[30], which picks SUB and SRA.
	function automatic defines::alu_op_t alu_sel(input logic [2:0] funct3, input logic alt);
		defines::alu_op_t op;
		case (funct3)
			3'b000:  op = alt ? defines::SUB : defines::ADD;
			3'b001:  op = defines::SLL;
			3'b010:  op = defines::SLT;
			3'b011:  op = defines::SLTU;
			3'b100:  op = defines::XOR;
			3'b101:  op = alt ? defines::SRA : defines::SRL;
			3'b110:  op = defines::OR;
			default: op = defines::AND;
		endcase
		return op;
	endfunction

	always_comb begin
		// Nothing is written and no register is read unless the format says so.
		// Unused register fields stay zero so they never match in the bypass.
		ctrl.opcode  = instr.r.opcode;
		ctrl.alu_op  = defines::ADD;
		ctrl.rd      = 5'd0;
		ctrl.rs1     = 5'd0;
		ctrl.rs2     = 5'd0;
		ctrl.imm     = defines::NULL;
		ctrl.use_imm = 1'b0;
		ctrl.reg_we  = 1'b0;
		ctrl.mem_we  = 1'b0;
		case (instr.r.opcode)
			defines::R: begin
				ctrl.alu_op = alu_sel(instr.r.funct3, instr.r.funct7[5]);
				ctrl.rd     = instr.r.rd;
				ctrl.rs1    = instr.r.rs1;
				ctrl.rs2    = instr.r.rs2;
				ctrl.reg_we = 1'b1;
			end
			defines::I, defines::JALR, defines::LOAD: begin
				// Only the shift-right immediate uses bit 30 as a function bit.
				if (instr.r.opcode == defines::I) begin
					ctrl.alu_op = alu_sel(instr.i.funct3,
						(instr.i.funct3 == 3'b101) && instr.i.imm12[10]);
				end
				if (instr.r.opcode == defines::JALR) ctrl.alu_op = defines::PC_PLUS4;
				ctrl.rd      = instr.i.rd;
				ctrl.rs1     = instr.i.rs1;
				ctrl.imm     = {{20{instr.i.imm12[11]}}, instr.i.imm12};
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
			end
			defines::STORE: begin
				ctrl.rs1     = instr.s.rs1;
				ctrl.rs2     = instr.s.rs2;
				ctrl.imm     = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
				ctrl.use_imm = 1'b1;
				ctrl.mem_we  = 1'b1;
			end
			defines::B: begin
				// The compare is a subtract, and the target offset is kept for reference.
				ctrl.alu_op = defines::SUB;
				ctrl.rs1    = instr.s.rs1;
				ctrl.rs2    = instr.s.rs2;
				ctrl.imm    = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0],
					instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
			end
			defines::LUI, defines::AUIPC: begin
				ctrl.alu_op  = (instr.u.opcode == defines::LUI) ? defines::PASS_B : defines::ADD;
				ctrl.rd      = instr.u.rd;
				ctrl.imm     = {instr.u.imm20, 12'b0};
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
			end
			defines::JAL: begin
				ctrl.alu_op  = defines::PC_PLUS4;
				ctrl.rd      = instr.u.rd;
				ctrl.imm     = {{12{instr.u.imm20[19]}}, instr.u.imm20[7:0],
					instr.u.imm20[8], instr.u.imm20[18:9], 1'b0};
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
			end
			// FENCE, SYSTEM and unknown opcodes have no effect.
			default: ;
		endcase
	end

endmodule : decode

// File: defines.sv
`include "core_params.svh"

package defines;

	// One data word as it moves between the stages.
	typedef logic [`XLEN-1:0] data_t;

	// Written back when an instruction produces no register result.
	localparam data_t NULL = '0;

	// RV32I base opcodes, held in bits [6:0] of every instruction word.
	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111,
		SYS   = 7'b1110011
	} opcode_t;

	// Operations the ALU knows how to carry out.
	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B, PC_PLUS4
	} alu_op_t;

	// The same 32-bit word seen through the four base encodings.
	// The opcode sits at [6:0] in all of them.
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			opcode_t    opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			opcode_t     opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			opcode_t    opcode;
		} s;
		struct packed {
			logic [19:0] imm20;
			logic [4:0]  rd;
			opcode_t     opcode;
		} u;
	} instr_t;

	// Control word produced by the decoder for one instruction.
	typedef struct packed {
		opcode_t    opcode;
		alu_op_t    alu_op;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		data_t      imm;
		logic       use_imm;
		logic       reg_we;
		logic       mem_we;
	} ctrl_t;

	// One incoming instruction; the execute stage register holds the same shape.
	typedef struct packed {
		logic   valid;
		data_t  pc;
		instr_t instr;
	} in_t;

	// Writeback stage register, filled from the execute stage.
	typedef struct packed {
		logic   valid;
		data_t  pc;
		instr_t instr;
		ctrl_t  ctrl;
		data_t  alu_result;
	} wb_stage_t;

	// Report of one retired instruction.
	typedef struct packed {
		logic       valid;
		data_t      pc;
		instr_t     instr;
		logic       we;
		logic [4:0] rd;
		data_t      data;
	} retire_t;

endpackage : defines

// File: core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Width of one data word and of every register in the core.
`define XLEN 32

// Number of architectural integer registers, x0 included.
`define NREGS 32

// Depth of the local data memory in words.
// The word index is the byte address above bit 1, modulo this depth.
`define DMEM_WORDS 64

`endif
